/* filterPkg.sv */
`default_nettype none

package filterPkg;

    // Decimation geometry
    localparam int dsr = 4;
    localparam int staggerCount = 2;
    localparam int lookahead = 8;
    localparam int lookback = 8;
    localparam int blockLen = dsr * staggerCount;
    localparam int windowLen = lookahead + lookback + dsr * (staggerCount - 1);
    localparam int lutSize = 4;

    // Coefficient and accumulator formats
    localparam int coefWidth = 16;
    localparam int coefFrac = 14;
    localparam int accWidth = 18;

    typedef logic signed [coefWidth-1:0] coef_t;
    typedef coef_t [0:lookahead-1] coefTable_t;

    // Index 0 is the tap next to the decimation point
    localparam coefTable_t lookaheadCoef = '{3000, 2500, 1800, 1000, 300, -200, -400, -300};
    localparam coefTable_t lookbackCoef = '{3000, 2500, 1800, 1000, 300, -200, -400, -300};

    // Pipeline depth and output alignment
    localparam int pipeBlocks = 3;
    localparam int fillBlocks = (windowLen + blockLen - 1) / blockLen + pipeBlocks;
    // First flagged word is branch 1 of block fillBlocks - pipeBlocks - 2
    localparam int firstPoint = blockLen * (fillBlocks - pipeBlocks - 1) - lookahead;

    typedef struct packed {
        logic signed [accWidth-1:0] sum;
        logic                       phaseTag;
    } branchResult_t;

endpackage

`default_nettype wire

/* fxpPkg.sv */
`default_nettype none

package fxpPkg;

    // Signed Q0.11 before offset coding
    localparam int outWidth = 12;
    localparam int outFrac = 11;

    localparam int roundShift = filterPkg::coefFrac - outFrac;
    localparam int roundHalf = 1 << (roundShift - 1);

    // Saturation limits
    localparam int outMax = (1 << (outWidth - 1)) - 1;
    localparam int outMin = -(1 << (outWidth - 1));

    // Offset binary zero
    localparam logic [outWidth-1:0] midScale = {1'b1, {(outWidth - 1){1'b0}}};

endpackage

`default_nettype wire

/* decimationCounter.sv */
`default_nettype none

module decimationCounter (
    input  logic clkOut,
    input  logic rst,
    output logic blockTick,
    output logic outTick,
    output logic valid
);
    import filterPkg::*;

    localparam int phaseBits = $clog2(blockLen);
    localparam int countBits = $clog2(fillBlocks + 1);

    logic [phaseBits-1:0] phaseCount;
    logic [countBits-1:0] blockCount;

    always_ff @(posedge clkOut) begin
        if (!rst) begin
            phaseCount <= '0;
        end else if (blockTick) begin
            phaseCount <= '0;
        end else begin
            phaseCount <= phaseCount + 1'b1;
        end
    end

    assign blockTick = (phaseCount == phaseBits'(blockLen - 1));
    assign outTick = ((phaseCount % phaseBits'(dsr)) == phaseBits'(dsr - 1));

    // Saturating block count gates valid
    always_ff @(posedge clkOut) begin
        if (!rst) begin
            blockCount <= '0;
            valid <= 1'b0;
        end else begin
            if (blockTick && blockCount != countBits'(fillBlocks)) begin
                blockCount <= blockCount + 1'b1;
            end
            // Wait for a block boundary, first flagged word is a branch 1 result
            if (outTick && blockTick && blockCount == countBits'(fillBlocks)) begin
                valid <= 1'b1;
            end
        end
    end

    blockPeriod: assert property (
        @(posedge clkOut) disable iff (!rst)
        blockTick |=> !blockTick [*blockLen - 1]
    );

endmodule

`default_nettype wire

/* sampleWindow.sv */
`default_nettype none

module sampleWindow (
    input  logic                           clkOut,
    input  logic                           rst,
    input  logic                           bitIn,
    input  logic                           blockTick,
    output logic [filterPkg::windowLen-1:0] windowBits
);
    import filterPkg::*;

    // Newest sample at bit 0
    logic [blockLen-2:0] packBits;

    always_ff @(posedge clkOut) begin
        packBits <= {packBits[blockLen-3:0], bitIn};
    end

    // The sample on the tick edge completes the block
    always_ff @(posedge clkOut) begin
        if (blockTick) begin
            windowBits <= {windowBits[windowLen-blockLen-1:0], packBits, bitIn};
        end
    end

    // Each pushed block holds only post-reset samples
    newBlockKnown: assert property (
        @(posedge clkOut) disable iff (!rst)
        blockTick |=> !$isunknown(windowBits[blockLen-1:0])
    );

endmodule

`default_nettype wire

/* lutDotProduct.sv */
`default_nettype none

module lutDotProduct #(
    parameter filterPkg::coefTable_t coefTable = '0,
    parameter bit                    reversed = 1'b0
) (
    input  logic                                clkOut,
    input  logic                                blockTick,
    input  logic [filterPkg::lookahead-1:0]     taps,
    output logic signed [filterPkg::accWidth-1:0] sum
);
    import filterPkg::*;

    localparam int tapCount = lookahead;
    localparam int groups = tapCount / lutSize;
    localparam int lutEntries = 1 << lutSize;

    typedef logic signed [accWidth-1:0] entry_t;
    typedef entry_t [lutEntries-1:0] entryTable_t;
    typedef entryTable_t [groups-1:0] allTables_t;

    // Bit k of the address set means +coef, clear means -coef
    function automatic allTables_t buildTables();
        allTables_t luts;
        entry_t acc;
        entry_t coef;
        for (int g = 0; g < groups; g++) begin
            for (int addr = 0; addr < lutEntries; addr++) begin
                acc = '0;
                for (int k = 0; k < lutSize; k++) begin
                    coef = entry_t'($signed(coefTable[g * lutSize + k]));
                    if (addr[k]) begin
                        acc = acc + coef;
                    end else begin
                        acc = acc - coef;
                    end
                end
                luts[g][addr] = acc;
            end
        end
        return luts;
    endfunction

    localparam allTables_t luts = buildTables();

    // ordered[j] pairs with coefTable[j]
    logic [tapCount-1:0] ordered;

    for (genvar j = 0; j < tapCount; j++) begin : gOrder
        assign ordered[j] = reversed ? taps[tapCount-1-j] : taps[j];
    end

    entry_t lutReg [groups];
    entry_t treeSum;

    always_ff @(posedge clkOut) begin
        if (blockTick) begin
            for (int g = 0; g < groups; g++) begin
                lutReg[g] <= luts[g][ordered[g*lutSize +: lutSize]];
            end
        end
    end

    always_comb begin
        treeSum = '0;
        for (int g = 0; g < groups; g++) begin
            treeSum = treeSum + lutReg[g];
        end
    end

    always_ff @(posedge clkOut) begin
        if (blockTick) begin
            sum <= treeSum;
        end
    end

endmodule

`default_nettype wire

/* staggerBranch.sv */
`default_nettype none

module staggerBranch #(
    parameter int phase = 0
) (
    input  logic                            clkOut,
    input  logic                            blockTick,
    input  logic [filterPkg::windowLen-1:0] windowBits,
    output filterPkg::branchResult_t        result
);
    import filterPkg::*;

    // Branch 0 reads dsr samples further back than branch 1
    localparam int aheadBase = (staggerCount - 1 - phase) * dsr;
    localparam int backBase = lookahead + aheadBase;

    logic signed [accWidth-1:0] aheadSum;
    logic signed [accWidth-1:0] backSum;
    logic signed [accWidth-1:0] totalSum;

    // Lookahead taps arrive newest first
    lutDotProduct #(
        .coefTable(lookaheadCoef),
        .reversed(1'b1)
    ) i_ahead (
        .clkOut(clkOut),
        .blockTick(blockTick),
        .taps(windowBits[aheadBase +: lookahead]),
        .sum(aheadSum)
    );

    lutDotProduct #(
        .coefTable(lookbackCoef),
        .reversed(1'b0)
    ) i_back (
        .clkOut(clkOut),
        .blockTick(blockTick),
        .taps(windowBits[backBase +: lookback]),
        .sum(backSum)
    );

    assign totalSum = aheadSum + backSum;

    always_ff @(posedge clkOut) begin
        if (blockTick) begin
            result <= '{sum: totalSum, phaseTag: 1'(phase)};
        end
    end

endmodule

`default_nettype wire

/* resultSerializer.sv */
`default_nettype none

module resultSerializer (
    input  logic                     clkOut,
    input  logic                     rst,
    input  logic                     blockTick,
    input  logic                     outTick,
    input  filterPkg::branchResult_t branch0,
    input  filterPkg::branchResult_t branch1,
    output filterPkg::branchResult_t head
);
    import filterPkg::*;

    branchResult_t slots [staggerCount];

    always_ff @(posedge clkOut) begin
        if (!rst) begin
            // Zero sums, tags in branch order
            for (int i = 0; i < staggerCount; i++) begin
                slots[i].sum <= '0;
                slots[i].phaseTag <= 1'(i);
            end
        end else if (blockTick) begin
            slots[0] <= branch0;
            slots[1] <= branch1;
        end else if (outTick) begin
            for (int i = 0; i < staggerCount - 1; i++) begin
                slots[i] <= slots[i+1];
            end
            slots[staggerCount-1] <= '0;
        end
    end

    assign head = slots[0];

    // Mid-block tick sees branch 0, the next tick sees branch 1
    tagAlternates: assert property (
        @(posedge clkOut) disable iff (!rst)
        (outTick && !blockTick) |-> (head.phaseTag == 1'b0) ##dsr (head.phaseTag == 1'b1)
    );

endmodule

`default_nettype wire

/* outputFormatter.sv */
`default_nettype none

module outputFormatter (
    input  logic                          clkOut,
    input  logic                          rst,
    input  logic                          outTick,
    input  filterPkg::branchResult_t      head,
    output logic [fxpPkg::outWidth-1:0]   dataOut,
    output logic                          outStrobe
);
    import filterPkg::*;
    import fxpPkg::*;

    localparam int shiftedWidth = accWidth - roundShift;

    logic signed [accWidth-1:0]     biased;
    logic signed [shiftedWidth-1:0] rounded;
    logic signed [outWidth-1:0]     clamped;
    logic [outWidth-1:0]            offsetWord;

    // Round half up, then drop the extra fraction bits
    assign biased = head.sum + accWidth'(roundHalf);
    assign rounded = shiftedWidth'(biased >>> roundShift);

    always_comb begin
        if (rounded > outMax) begin
            clamped = outWidth'(outMax);
        end else if (rounded < outMin) begin
            clamped = outWidth'(outMin);
        end else begin
            clamped = outWidth'(rounded);
        end
    end

    // Offset binary
    assign offsetWord = {~clamped[outWidth-1], clamped[outWidth-2:0]};

    always_ff @(posedge clkOut) begin
        if (!rst) begin
            dataOut <= midScale;
            outStrobe <= 1'b0;
        end else begin
            outStrobe <= outTick;
            if (outTick) begin
                dataOut <= offsetWord;
            end
        end
    end

endmodule

`default_nettype wire

/* firStaggered.sv */
`default_nettype none

module firStaggered (
    input  logic                        clkOut,
    input  logic                        rst,
    input  logic                        bitIn,
    output logic [fxpPkg::outWidth-1:0] dataOut,
    output logic                        outStrobe,
    output logic                        valid
);
    import filterPkg::*;

    logic                 blockTick;
    logic                 outTick;
    logic [windowLen-1:0] windowBits;
    branchResult_t        branchOut [staggerCount];
    branchResult_t        head;

    decimationCounter i_counter (
        .clkOut(clkOut),
        .rst(rst),
        .blockTick(blockTick),
        .outTick(outTick),
        .valid(valid)
    );

    sampleWindow i_window (
        .clkOut(clkOut),
        .rst(rst),
        .bitIn(bitIn),
        .blockTick(blockTick),
        .windowBits(windowBits)
    );

    for (genvar i = 0; i < staggerCount; i++) begin : gBranch
        staggerBranch #(
            .phase(i)
        ) i_branch (
            .clkOut(clkOut),
            .blockTick(blockTick),
            .windowBits(windowBits),
            .result(branchOut[i])
        );
    end

    resultSerializer i_serializer (
        .clkOut(clkOut),
        .rst(rst),
        .blockTick(blockTick),
        .outTick(outTick),
        .branch0(branchOut[0]),
        .branch1(branchOut[1]),
        .head(head)
    );

    outputFormatter i_formatter (
        .clkOut(clkOut),
        .rst(rst),
        .outTick(outTick),
        .head(head),
        .dataOut(dataOut),
        .outStrobe(outStrobe)
    );

endmodule

`default_nettype wire

/* tbFirStaggered.sv */
`default_nettype none

module tbFirStaggered;
    timeunit 1ns;
    timeprecision 1ps;

    import filterPkg::*;
    import fxpPkg::*;

    localparam int clkPeriod = 40;
    localparam int resetCycles = 3;
    localparam int fillCycles = fillBlocks * blockLen;
    localparam int warmSteps = 12;
    localparam int constSteps = fillCycles + 8 * dsr;
    localparam int rateSteps = 120;
    localparam int randomSteps = 400;
    localparam int satSteps = 160;
    localparam int midSteps = 130;
    localparam int tailSteps = 100;
    // Nine resets, two fill checks, the valid wait and the stimulus of each test
    localparam int totalCycles = 9 * (resetCycles + 1) + warmSteps + 2 * fillCycles
        + 2 * blockLen + 2 * constSteps + rateSteps + randomSteps + satSteps + midSteps
        + tailSteps;
    localparam int marginCycles = 64;

    logic clkOut = 1'b0;
    logic rst;
    logic bitIn;
    logic [outWidth-1:0] dataOut;
    logic outStrobe;
    logic valid;

    logic history[$];
    logic [31:0] lfsrState = 32'h3c25_7f32;
    int outIndex = 0;
    int errorCount = 0;
    logic obsStrobe;
    logic obsValid;
    logic [outWidth-1:0] obsData;

    firStaggered i_dut (
        .clkOut(clkOut),
        .rst(rst),
        .bitIn(bitIn),
        .dataOut(dataOut),
        .outStrobe(outStrobe),
        .valid(valid)
    );

    always #(clkPeriod / 2) clkOut = ~clkOut;

    task automatic abortRun(input string line);
        errorCount++;
        $display("%s", line);
        $display("Done: errors found");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    // Galois LFSR stepped once per stimulus bit
    function automatic logic nextBit();
        lfsrState = lfsrState[0] ? (lfsrState >> 1) ^ 32'h8020_0003 : lfsrState >> 1;
        return lfsrState[0];
    endfunction

    // Bit 1 weighs +1, bit 0 weighs -1
    function automatic int modelSum(input int p);
        int acc;
        acc = 0;
        for (int j = 0; j < lookahead; j++) begin
            acc += int'($signed(lookaheadCoef[j])) * (history[p + j] ? 1 : -1);
            acc += int'($signed(lookbackCoef[j])) * (history[p - 1 - j] ? 1 : -1);
        end
        return acc;
    endfunction

    function automatic logic [outWidth-1:0] formatWord(input int sum);
        int level;
        level = (sum + (1 << (roundShift - 1))) >>> roundShift;
        if (level > outMax) begin
            level = outMax;
        end else if (level < outMin) begin
            level = outMin;
        end
        return outWidth'(level - outMin);
    endfunction

    // History index 0 is the bit sampled on the first edge out of reset
    task automatic applyReset();
        @(negedge clkOut);
        rst = 1'b0;
        repeat (resetCycles) @(negedge clkOut);
        rst = 1'b1;
        history.delete();
        history.push_back(bitIn);
        outIndex = 0;
    endtask

    // Sample outputs mid-cycle and drive the next bit
    task automatic stepCycle(input logic b);
        logic [outWidth-1:0] expected;
        @(negedge clkOut);
        obsStrobe = outStrobe;
        obsValid = valid;
        obsData = dataOut;
        bitIn = b;
        history.push_back(b);
        if (obsStrobe && obsValid) begin
            expected = formatWord(modelSum(firstPoint + outIndex * dsr));
            assert (obsData === expected) else abortRun($sformatf(
                "Mismatch at %0t: output %0d expected %h got %h",
                $time, outIndex, expected, obsData));
            outIndex++;
        end
    endtask

    task automatic resetState();
        int waitSteps;
        applyReset();
        // Short run so both branch registers hold tagged results
        repeat (warmSteps) stepCycle(nextBit());
        applyReset();
        assert (valid === 1'b0 && outStrobe === 1'b0 && dataOut === formatWord(0))
            else abortRun("Outputs did not take their reset values");
        repeat (fillCycles) begin
            stepCycle(nextBit());
            assert (obsValid === 1'b0) else abortRun("valid rose before the pipeline filled");
        end
        waitSteps = 0;
        while (obsValid !== 1'b1) begin
            stepCycle(nextBit());
            waitSteps++;
            assert (waitSteps < 2 * blockLen) else abortRun("valid never rose after the fill");
        end
    endtask

    task automatic constantInput(input logic level);
        int total;
        int seen;
        total = 0;
        seen = 0;
        for (int j = 0; j < lookahead; j++) begin
            total += int'($signed(lookaheadCoef[j])) + int'($signed(lookbackCoef[j]));
        end
        if (!level) begin
            total = -total;
        end
        // The first sample out of reset is part of the window too
        bitIn = level;
        applyReset();
        repeat (constSteps) begin
            stepCycle(level);
            if (obsStrobe && obsValid) begin
                assert (obsData === formatWord(total)) else abortRun($sformatf(
                    "Mismatch at %0t: constant input expected %h got %h",
                    $time, formatWord(total), obsData));
                seen++;
            end
        end
        assert (seen >= 4) else abortRun("Too few outputs with constant input");
    endtask

    task automatic outputRate();
        int lastStep;
        int gaps;
        lastStep = -1;
        gaps = 0;
        applyReset();
        for (int s = 0; s < rateSteps; s++) begin
            stepCycle(nextBit());
            if (obsStrobe && obsValid) begin
                if (lastStep >= 0) begin
                    assert (s - lastStep == dsr) else abortRun($sformatf(
                        "Mismatch at %0t: strobe gap expected %0d got %0d",
                        $time, dsr, s - lastStep));
                    gaps++;
                end
                lastStep = s;
            end
        end
        assert (gaps > 10) else abortRun("Too few output strobes while valid was high");
    endtask

    task automatic randomStream();
        applyReset();
        repeat (randomSteps) stepCycle(nextBit());
        assert (outIndex >= 80) else abortRun("Too few outputs checked on the random stream");
    endtask

    task automatic saturationCoding();
        int clampedSeen;
        logic b;
        clampedSeen = 0;
        applyReset();
        for (int n = 1; n < satSteps; n++) begin
            // Ones at 3..12 of every 16 match the coefficient signs around p = 8 mod 16
            b = (n % 16 >= 3) && (n % 16 <= 12);
            stepCycle(b);
            if (obsStrobe && obsValid && obsData === outWidth'(outMax - outMin)) begin
                clampedSeen++;
            end
        end
        assert (clampedSeen > 0) else abortRun("No output reached the clamped full-scale word");
    endtask

    task automatic midRunReset();
        applyReset();
        repeat (midSteps) stepCycle(nextBit());
        assert (obsValid === 1'b1) else abortRun("valid was low before the mid-run reset");
        applyReset();
        assert (valid === 1'b0) else abortRun("valid stayed high through the reset");
        repeat (fillCycles) begin
            stepCycle(nextBit());
            assert (obsValid === 1'b0) else abortRun("Fill count did not restart after reset");
        end
        repeat (tailSteps) stepCycle(nextBit());
        assert (outIndex > 15) else abortRun("Too few outputs after the mid-run reset");
    endtask

    initial begin
        #((totalCycles + marginCycles) * clkPeriod);
        abortRun("Timeout: the tests did not finish in the expected time");
    end

    initial begin
        rst = 1'b0;
        bitIn = 1'b0;
        resetState();
        constantInput(1'b1);
        constantInput(1'b0);
        outputRate();
        randomStream();
        saturationCoding();
        midRunReset();
        if (errorCount == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
filterPkg.sv
fxpPkg.sv
decimationCounter.sv
sampleWindow.sv
lutDotProduct.sv
staggerBranch.sv
resultSerializer.sv
outputFormatter.sv
firStaggered.sv
tbFirStaggered.sv

/* runSim.sh */
#!/bin/sh
# Build and run the filter testbench, pass only if the log shows a clean finish
rm -f sim.log &&
verilator --binary --assert --timescale 1ns/1ps --top-module tbFirStaggered -f sim.f &&
./obj_dir/VtbFirStaggered > sim.log 2>&1
grep -qx 'Done: no errors' sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
